//--- source/px_pkg.sv
`default_nettype none

package px_pkg;

	localparam int def_addr_w = 12;	// Bus address width unless overridden

	typedef logic [15:0] word_t;	// Machine word

	// Codes 6..15 have no meaning and raise the alarm
	typedef enum logic [3:0] {
		op_lwt = 4'h0,	// ACC <- argument
		op_lw  = 4'h1,	// ACC <- mem[argument]
		op_aw  = 4'h2,	// ACC <- ACC + mem[argument]
		op_rw  = 4'h3,	// mem[argument] <- ACC
		op_ou  = 4'h4,	// Output ACC
		op_hlt = 4'h5	// Stop accepting
	} opcode_t;

	typedef struct packed {
		opcode_t     op;	// Top nibble
		logic [11:0] arg;	// Immediate or word address
	} instr_t;

	// One flop per state, as on the P-X sheets
	typedef enum logic [5:0] {
		st_k1 = 6'b000001,	// Wait for instruction
		st_p1 = 6'b000010,	// Decode latch
		st_wr = 6'b000100,	// Bus read
		st_ww = 6'b001000,	// Bus write
		st_p4 = 6'b010000,	// Arithmetic
		st_we = 6'b100000	// Emit result
	} st_t;

	typedef struct packed {
		opcode_t    op;	// Instruction that finished
		logic       alarm;	// Sticky illegal-opcode alarm
		logic       halt;	// Set on op_hlt
		logic [9:0] rsv;	// Spare, always zero
		word_t      acc;	// ACC after the instruction
	} res_t;

endpackage

`default_nettype wire

//--- source/px_skid.sv
`default_nettype none

module px_skid import px_pkg::*; #(
	parameter type payload_t = word_t
) (
	input  logic     got,
	input  logic     clo_,
	input  logic     s_valid,
	output logic     s_ready,
	input  payload_t s_data,
	output logic     m_valid,
	input  logic     m_ready,
	output payload_t m_data
);

	logic     ovf_valid;	// Overflow slot holds an entry
	logic     main_free;	// Head leaves or is empty this cycle
	payload_t main_q;	// Head entry, drives m_data
	payload_t ovf_q;	// Entry parked while the head stalls

	assign main_free = m_ready | ~m_valid;
	assign s_ready = ~ovf_valid;	// Registered, no path from m_ready
	assign m_data = main_q;

	always_ff @(posedge got, negedge clo_) begin
		if (!clo_) begin
			m_valid <= 1'b0;
			ovf_valid <= 1'b0;
		end else if (main_free) begin
			if (ovf_valid) begin
				m_valid <= 1'b1;	// Older entry moves up first
				ovf_valid <= 1'b0;
			end else begin
				m_valid <= s_valid;	// Take new one straight into head
			end
		end else if (s_valid && s_ready) begin
			ovf_valid <= 1'b1;	// Head stuck, park input
		end
	end

	// Data path, no reset
	always_ff @(posedge got) begin
		if (main_free)
			main_q <= ovf_valid ? ovf_q : s_data;	// Keeps order
		if (!main_free && !ovf_valid)
			ovf_q <= s_data;
	end

endmodule

`default_nettype wire

//--- source/px_decode.sv
`default_nettype none

module px_decode import px_pkg::*; #(
	parameter int addr_w = def_addr_w
) (
	input  instr_t            instr,
	output logic              need_read,
	output logic              need_write,
	output logic              need_alu,
	output logic              use_imm,
	output logic              is_halt,
	output logic              illegal,
	output logic [addr_w-1:0] bus_addr
);

	// need_alu: read data is added to ACC instead of replacing it
	// use_imm: argument goes to ACC through state P4
	always_comb begin
		need_read = 1'b0;
		need_write = 1'b0;
		need_alu = 1'b0;
		use_imm = 1'b0;
		is_halt = 1'b0;
		illegal = 1'b0;
		case (instr.op)
			op_lwt: begin
				use_imm = 1'b1;	// P1 -> P4 -> WE
			end
			op_lw: begin
				need_read = 1'b1;	// P1 -> WR -> WE, load
			end
			op_aw: begin
				need_read = 1'b1;	// P1 -> WR -> WE
				need_alu = 1'b1;	// Add at end of read
			end
			op_rw: begin
				need_write = 1'b1;	// P1 -> WW -> WE
			end
			op_ou: begin
				need_read = 1'b0;	// Straight to WE
			end
			op_hlt: begin
				is_halt = 1'b1;	// Emit, then block K1
			end
			default: begin
				illegal = 1'b1;	// No bus cycle, alarm only
			end
		endcase
	end

	assign bus_addr = addr_w'(instr.arg);	// Word address from argument

endmodule

`default_nettype wire

//--- source/px_state_ctl.sv
`default_nettype none

module px_state_ctl import px_pkg::*; #(
	parameter int addr_w = def_addr_w
) (
	input  logic              got,
	input  logic              clo_,
	input  logic              dec_valid,
	output logic              dec_ready,
	input  instr_t            dec_instr,
	output logic              zg,
	input  logic              ok,
	output logic              bus_we,
	output logic [addr_w-1:0] bus_addr,
	input  word_t             bus_wdata,
	output word_t             bus_wdata_out,
	output logic              ld_acc,
	output logic              use_imm,
	output logic              add_acc,
	output logic              set_alarm,
	output logic              emit,
	output logic              halt,
	input  logic              res_ready,
	output opcode_t           op
);

	st_t    st;	// One-hot state flops
	instr_t ir;	// Latched instruction
	word_t  wdata_q;	// Write data held for the whole bus cycle

	logic k1, p1, wr, ww, p4, we;	// State decodes
	logic need_read, need_write, need_alu, imm_op, is_halt, illegal;
	logic accept;	// Instruction taken in K1
	logic bus_done;	// OK seen while ZG up
	logic ek1, ep1, ewr, eww, ep4, ewe;	// Enter conditions

	px_decode #(
		.addr_w(addr_w)
	) px_decode_inst (
		.instr(ir),
		.need_read(need_read),
		.need_write(need_write),
		.need_alu(need_alu),
		.use_imm(imm_op),
		.is_halt(is_halt),
		.illegal(illegal),
		.bus_addr(bus_addr)
	);

	assign k1 = (st == st_k1);
	assign p1 = (st == st_p1);
	assign wr = (st == st_wr);
	assign ww = (st == st_ww);
	assign p4 = (st == st_p4);
	assign we = (st == st_we);

	assign dec_ready = k1 & ~halt;	// Closed for good after HLT
	assign accept = dec_valid & dec_ready;
	assign bus_done = zg & ok;	// OK only counts under ZG

	// Each state: entry from its predecessor, or hold
	assign ek1 = (k1 & ~accept) | (we & res_ready);
	assign ep1 = accept;
	assign ewr = (p1 & need_read) | (wr & ~bus_done);
	assign eww = (p1 & need_write) | (ww & ~bus_done);
	assign ep4 = p1 & imm_op;
	assign ewe = (p1 & ~need_read & ~need_write & ~imm_op)	// OU, HLT, illegal
		| ((wr | ww) & bus_done)	// Bus cycle finished
		| p4
		| (we & ~res_ready);	// Back-pressure hold

	always_ff @(posedge got, negedge clo_) begin
		if (!clo_)
			st <= st_k1;
		else
			st <= st_t'({ewe, ep4, eww, ewr, ep1, ek1});	// Bit order as in st_t
	end

	// Bus request, up with the address, down after the OK edge
	always_ff @(posedge got, negedge clo_) begin
		if (!clo_)
			zg <= 1'b0;
		else if (p1 && (need_read || need_write))
			zg <= 1'b1;
		else if (bus_done)
			zg <= 1'b0;
	end

	always_ff @(posedge got, negedge clo_) begin
		if (!clo_)
			halt <= 1'b0;
		else if (p1 && is_halt)
			halt <= 1'b1;	// Sticky until clo_
	end

	always_ff @(posedge got) begin
		if (accept)
			ir <= dec_instr;
		if (p1 && need_write)
			wdata_q <= bus_wdata;	// ACC snapshot for RW
	end

	assign bus_we = ww;
	assign bus_wdata_out = wdata_q;
	assign op = ir.op;

	// Strobes to the result block
	assign ld_acc = p4 | (wr & bus_done & ~need_alu);	// LWT in P4, LW at OK
	assign use_imm = p4;	// Source: argument in P4, else bus
	assign add_acc = wr & bus_done & need_alu;	// AW at OK
	assign set_alarm = p1 & illegal;
	assign emit = we & res_ready;

endmodule

`default_nettype wire

//--- source/px_result.sv
`default_nettype none

module px_result import px_pkg::*; (
	input  logic    got,
	input  logic    clo_,
	input  logic    ld_acc,
	input  logic    use_imm,
	input  logic    add_acc,
	input  logic    set_alarm,
	input  logic    emit,
	input  logic    halt,
	input  opcode_t op,
	input  word_t   imm,
	input  word_t   bus_rdata,
	output word_t   acc,
	output logic    res_valid,
	input  logic    res_ready,
	output res_t    res
);

	logic  alarm;	// Sticky illegal-opcode flag
	word_t acc_src;	// Load source

	assign acc_src = use_imm ? imm : bus_rdata;

	// ACC starts from zero after clo_
	always_ff @(posedge got, negedge clo_) begin
		if (!clo_)
			acc <= '0;
		else if (ld_acc)
			acc <= acc_src;
		else if (add_acc)
			acc <= acc + bus_rdata;	// Wraps mod 2^16
	end

	always_ff @(posedge got, negedge clo_) begin
		if (!clo_)
			alarm <= 1'b0;
		else if (set_alarm)
			alarm <= 1'b1;	// Stays until clo_
	end

	// Output register, held until the skid takes it
	always_ff @(posedge got, negedge clo_) begin
		if (!clo_)
			res_valid <= 1'b0;
		else if (emit)
			res_valid <= 1'b1;	// New record replaces the one leaving
		else if (res_ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge got) begin
		if (emit) begin
			res.op <= op;
			res.alarm <= alarm;	// Set in P1, long before WE
			res.halt <= halt;
			res.rsv <= '0;
			res.acc <= acc;	// Already updated in WR or P4
		end
	end

endmodule

`default_nettype wire

//--- source/px_top.sv
`default_nettype none

module px_top import px_pkg::*; #(
	parameter int addr_w = def_addr_w
) (
	input  logic              got,
	input  logic              clo_,
	input  logic              in_valid,
	output logic              in_ready,
	input  instr_t            in_instr,
	output logic              zg,
	input  logic              ok,
	output logic              bus_we,
	output logic [addr_w-1:0] bus_addr,
	output word_t             bus_wdata,
	input  word_t             bus_rdata,
	output logic              out_valid,
	input  logic              out_ready,
	output res_t              out_res
);

	logic    dec_valid, dec_ready;	// Input skid to sequencer
	instr_t  dec_instr;
	word_t   acc;	// Also the write data source
	logic    ld_acc, use_imm, add_acc, set_alarm, emit, halt;
	opcode_t op;
	logic    res_valid, res_ready;	// Result block to output skid
	res_t    res;

	px_skid #(
		.payload_t(instr_t)
	) in_skid_inst (
		.got(got),
		.clo_(clo_),
		.s_valid(in_valid),
		.s_ready(in_ready),
		.s_data(in_instr),
		.m_valid(dec_valid),
		.m_ready(dec_ready),
		.m_data(dec_instr)
	);

	px_state_ctl #(
		.addr_w(addr_w)
	) px_state_ctl_inst (
		.got(got),
		.clo_(clo_),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_instr(dec_instr),
		.zg(zg),
		.ok(ok),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(acc),
		.bus_wdata_out(bus_wdata),
		.ld_acc(ld_acc),
		.use_imm(use_imm),
		.add_acc(add_acc),
		.set_alarm(set_alarm),
		.emit(emit),
		.halt(halt),
		.res_ready(res_ready),
		.op(op)
	);

	px_result px_result_inst (
		.got(got),
		.clo_(clo_),
		.ld_acc(ld_acc),
		.use_imm(use_imm),
		.add_acc(add_acc),
		.set_alarm(set_alarm),
		.emit(emit),
		.halt(halt),
		.op(op),
		.imm(word_t'(bus_addr)),	// Argument, zero-extended
		.bus_rdata(bus_rdata),
		.acc(acc),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res(res)
	);

	px_skid #(
		.payload_t(res_t)
	) out_skid_inst (
		.got(got),
		.clo_(clo_),
		.s_valid(res_valid),
		.s_ready(res_ready),
		.s_data(res),
		.m_valid(out_valid),
		.m_ready(out_ready),
		.m_data(out_res)
	);

endmodule

`default_nettype wire

//--- verif/px_assertions.sv
`default_nettype none

module px_assertions import px_pkg::*; #(
	parameter int addr_w = def_addr_w
) (
	input  logic              got,
	input  logic              clo_,
	input  st_t               st,
	input  logic              zg,
	input  logic              ok,
	input  logic              bus_we,
	input  logic [addr_w-1:0] bus_addr,
	input  word_t             bus_wdata_out,
	input  logic              dec_valid,
	input  logic              dec_ready,
	input  instr_t            dec_instr
);

	int unsigned fail_cnt;	// Read by the testbench at the end

	initial fail_cnt = 0;

	state_onehot: assert property (@(posedge got) disable iff (!clo_) $onehot(st))
		else begin
			$error("state vector not one-hot: %b", st);
			fail_cnt++;
		end

	// Request held with address, direction and data until OK
	zg_hold: assert property (@(posedge got) disable iff (!clo_)
		zg && !ok |=> zg && $stable(bus_addr) && $stable(bus_we) && $stable(bus_wdata_out))
		else begin
			$error("bus request or its address/data changed before OK");
			fail_cnt++;
		end

	zg_drop: assert property (@(posedge got) disable iff (!clo_) zg && ok |=> !zg)
		else begin
			$error("bus request still up after the OK edge");
			fail_cnt++;
		end

	dec_hold: assert property (@(posedge got) disable iff (!clo_)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_instr))
		else begin
			$error("instruction stream dropped valid or changed before transfer");
			fail_cnt++;
		end

endmodule

`default_nettype wire

//--- verif/px_tb.sv
`default_nettype none

module px_tb import px_pkg::*; ();

	localparam int addr_w = 12;
	localparam int tbl_len = 40;	// Instructions in the table
	localparam int n_tests = 6;
	localparam int idle_cycles = 40;	// Quiet window after each test
	localparam int watchdog_cycles = tbl_len * 40;

	logic              got;
	logic              clo_;
	logic              in_valid;
	logic              in_ready;
	instr_t            in_instr;
	logic              zg;
	logic              ok;
	logic              bus_we;
	logic [addr_w-1:0] bus_addr;
	word_t             bus_wdata;
	word_t             bus_rdata;
	logic              out_valid;
	logic              out_ready;
	res_t              out_res;

	instr_t tbl_instr [tbl_len];	// Stimulus column
	string  test_name [n_tests];
	int     test_first [n_tests];
	int     test_len [n_tests];
	bit     test_stall [n_tests];	// Random out_ready stalls
	int     tbl_fill;
	int     test_fill;

	word_t bus_mem [4096];	// Bus memory model
	word_t ref_mem [4096];	// Reference copy of memory
	res_t  exp_q[$];	// Expected column, filled per test
	res_t  rec_q[$];	// Records taken from out_res

	logic [16:0] lfsr_state;
	bit          stall_en;
	bit          feed_stop;	// Halt seen, stop the feeder
	bit          bus_busy;
	int          bus_wait;
	int          bus_cycles;
	bit          wr_pending;
	logic [addr_w-1:0] lat_addr;
	word_t       lat_data;
	int          err_count;
	int          n_checks;

	px_top #(
		.addr_w(addr_w)
	) px_top_inst (
		.got(got),
		.clo_(clo_),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.zg(zg),
		.ok(ok),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res)
	);

	bind px_state_ctl px_assertions #(
		.addr_w(addr_w)
	) px_assertions_inst (
		.got(got),
		.clo_(clo_),
		.st(st),
		.zg(zg),
		.ok(ok),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata_out(bus_wdata_out),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_instr(dec_instr)
	);

	initial begin
		got = 1'b0;
		forever #4 got = ~got;
	end

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic take_bits(input int n, output int v);
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// One step per bit
			v = (v << 1) | lfsr_state[0];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			err_count++;
		end
	endtask

	task automatic add_test(input string name, input bit stall);
		test_name[test_fill] = name;
		test_first[test_fill] = tbl_fill;
		test_len[test_fill] = 0;
		test_stall[test_fill] = stall;
		test_fill++;
	endtask

	task automatic add_instr(input logic [3:0] op, input logic [11:0] arg);
		if (tbl_fill < tbl_len)
			tbl_instr[tbl_fill] = instr_t'({op, arg});
		tbl_fill++;
		test_len[test_fill-1]++;
	endtask

	task automatic build_table();
		tbl_fill = 0;
		test_fill = 0;
		add_test("imm_out", 1'b0);	// No bus traffic expected
		add_instr(op_lwt, 12'h123);
		add_instr(op_ou, 12'h000);
		add_instr(op_lwt, 12'hfff);
		add_instr(op_ou, 12'h000);
		add_test("bus_read", 1'b0);
		add_instr(op_lw, 12'h010);
		add_instr(op_aw, 12'h020);
		add_instr(op_aw, 12'habc);	// Sum wraps past 16 bits
		add_instr(op_lw, 12'h7ff);
		add_instr(op_aw, 12'h001);
		add_test("write_read", 1'b0);
		add_instr(op_lwt, 12'h321);
		add_instr(op_rw, 12'h040);
		add_instr(op_lwt, 12'h000);
		add_instr(op_lw, 12'h040);	// Reads back the store
		add_instr(op_aw, 12'h040);
		add_instr(op_rw, 12'h041);
		add_instr(op_lw, 12'h041);
		add_test("alarm", 1'b0);
		add_instr(op_lwt, 12'h005);
		add_instr(4'h9, 12'h000);	// Unknown code
		add_instr(op_ou, 12'h000);
		add_instr(op_lw, 12'h100);
		add_instr(4'hf, 12'habc);
		add_instr(op_ou, 12'h000);
		add_test("backpressure", 1'b1);
		add_instr(op_lwt, 12'h001);
		add_instr(op_aw, 12'h002);
		add_instr(op_aw, 12'h003);
		add_instr(op_ou, 12'h000);
		add_instr(op_rw, 12'h050);
		add_instr(op_lw, 12'h050);
		add_instr(op_aw, 12'h051);
		add_instr(op_lwt, 12'h007);
		add_instr(op_ou, 12'h000);
		add_instr(op_aw, 12'h052);
		add_instr(op_ou, 12'h000);
		add_instr(op_lw, 12'h050);
		add_test("halt", 1'b1);
		add_instr(op_lwt, 12'h0aa);
		add_instr(op_ou, 12'h000);
		add_instr(op_hlt, 12'h000);
		add_instr(op_lwt, 12'h055);	// Never executed
		add_instr(op_ou, 12'h000);
		add_instr(op_lwt, 12'h066);
	endtask

	// Reference model, stops at the first halt
	task automatic build_expected(input int first, input int n, output int n_exp,
		output int n_bus, output bit halted);
		word_t  acc;
		logic   alarm;
		instr_t ins;
		res_t   r;
		int     i;
		exp_q.delete();
		acc = '0;
		alarm = 1'b0;
		halted = 1'b0;
		n_exp = 0;
		n_bus = 0;
		for (i = 0; i < n && !halted; i++) begin
			ins = tbl_instr[first+i];
			case (ins.op)
				op_lwt: acc = word_t'(ins.arg);
				op_lw: begin
					acc = ref_mem[ins.arg];
					n_bus++;
				end
				op_aw: begin
					acc = acc + ref_mem[ins.arg];	// 16-bit wrap
					n_bus++;
				end
				op_rw: begin
					ref_mem[ins.arg] = acc;
					n_bus++;
				end
				op_ou: begin
				end
				op_hlt: halted = 1'b1;
				default: alarm = 1'b1;
			endcase
			r.op = ins.op;
			r.alarm = alarm;
			r.halt = halted;
			r.rsv = '0;
			r.acc = acc;
			exp_q.push_back(r);
			n_exp++;
		end
	endtask

	task automatic apply_reset(input bit stall);
		@(negedge got);
		clo_ = 1'b0;
		in_valid = 1'b0;
		@(posedge got);
		stall_en = stall;	// Sink reads it on falling edges only
		feed_stop = 1'b0;
		rec_q.delete();
		@(negedge got);
		repeat (15) @(negedge got);
		clo_ = 1'b1;
	endtask

	task automatic feed_instr(input int first, input int n);
		int   idx;
		logic take;
		idx = 0;
		@(negedge got);
		in_valid = 1'b1;
		in_instr = tbl_instr[first];
		while (idx < n && !feed_stop) begin
			take = in_ready;	// Decides the coming rising edge
			@(negedge got);
			if (take) begin
				idx++;
				if (idx < n)
					in_instr = tbl_instr[first+idx];
				else
					in_valid = 1'b0;
			end
		end
	endtask

	task automatic run_test(input int t);
		int  n_exp;
		int  n_bus;
		int  errs_before;
		int  cycles_before;
		int  i;
		bit  halted;
		bit  ready_seen;
		errs_before = err_count;
		apply_reset(test_stall[t]);
		build_expected(test_first[t], test_len[t], n_exp, n_bus, halted);
		cycles_before = bus_cycles;
		fork
			feed_instr(test_first[t], test_len[t]);
			begin
				while (rec_q.size() < n_exp)
					@(posedge got);
				feed_stop = 1'b1;
			end
		join
		for (i = 0; i < n_exp; i++)
			check_value($sformatf("%s record %0d", test_name[t], i), exp_q[i], rec_q[i]);
		ready_seen = 1'b0;
		repeat (idle_cycles) begin
			@(negedge got);
			ready_seen = ready_seen | in_ready;
		end
		@(posedge got);
		check_value({test_name[t], " record count"}, n_exp, rec_q.size());	// No duplicates
		check_value({test_name[t], " bus cycles"}, n_bus, bus_cycles - cycles_before);
		if (halted)
			check_value({test_name[t], " in_ready after halt"}, 0, ready_seen);
		$display("%-12s %0d records, %0d bus cycles, %0d errors", test_name[t], n_exp,
			bus_cycles - cycles_before, err_count - errs_before);
	endtask

	// Bus memory and output sink, all on falling edges
	initial begin : bus_and_sink
		int a;
		int delay_bits;
		int stall_bit;
		ok = 1'b0;
		bus_rdata = '0;
		out_ready = 1'b0;
		lfsr_state = 17'd79607;
		bus_busy = 1'b0;
		bus_wait = 0;
		bus_cycles = 0;
		wr_pending = 1'b0;
		lat_addr = '0;
		lat_data = '0;
		for (a = 0; a < 4096; a++)
			bus_mem[a] = word_t'(a) ^ 16'h5a5a;
		forever begin
			@(negedge got);
			if (ok) begin	// Cycle ended on the last rising edge
				if (wr_pending)
					bus_mem[lat_addr] = lat_data;
				ok = 1'b0;
				bus_busy = 1'b0;
				wr_pending = 1'b0;
			end else if (zg) begin
				if (!bus_busy) begin	// New request
					bus_busy = 1'b1;
					bus_cycles++;
					take_bits(2, delay_bits);
					bus_wait = delay_bits;	// 0 to 3 cycles
				end
				if (bus_wait == 0) begin
					ok = 1'b1;
					if (bus_we) begin
						wr_pending = 1'b1;
						lat_addr = bus_addr;
						lat_data = bus_wdata;
					end else begin
						bus_rdata = bus_mem[bus_addr];
					end
				end else begin
					bus_wait--;
				end
			end
			if (stall_en) begin
				take_bits(1, stall_bit);
				out_ready = stall_bit[0];
			end else begin
				out_ready = 1'b1;
			end
			if (out_valid && out_ready)
				rec_q.push_back(out_res);	// Transfers on the coming edge
		end
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge got);
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main_seq
		int a;
		int t;
		int asrt_fails;
		clo_ = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		stall_en = 1'b0;
		feed_stop = 1'b0;
		err_count = 0;
		n_checks = 0;
		for (a = 0; a < 4096; a++)
			ref_mem[a] = word_t'(a) ^ 16'h5a5a;
		build_table();
		for (t = 0; t < n_tests; t++)
			run_test(t);
		asrt_fails = px_top_inst.px_state_ctl_inst.px_assertions_inst.fail_cnt;
		err_count += asrt_fails;
		$display("%0d tests, %0d checks, %0d assertion failures, %0d errors", n_tests,
			n_checks, asrt_fails, err_count);
		if (err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
source/px_pkg.sv
source/px_skid.sv
source/px_decode.sv
source/px_state_ctl.sv
source/px_result.sv
source/px_top.sv
verif/px_assertions.sv
verif/px_tb.sv
